// ==== ipu_pkg.sv ====
// shared types and register map for the image processing unit.
package ipu_pkg;

    // one RGB camera sample.
    typedef struct packed {
        logic [11:0] red;
        logic [11:0] green;
        logic [11:0] blue;
    } pixel_t;

    // per-frame target result, also the FIFO payload.
    typedef struct packed {
        logic       present;
        logic [9:0] row;
        logic [9:0] col;
    } ipu_result_t;

    typedef struct packed {
        logic [11:0] thresh;
        logic        en;
    } ipu_cfg_t;

    typedef struct packed {
        logic        wr;
        logic        rd;
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        ack;
    } bus_resp_t;

    // byte offsets of the two registers from the base address.
    localparam logic [31:0] RESULT_OFS = 32'd0;
    localparam logic [31:0] CFG_OFS    = 32'd4;

    localparam logic [11:0] CFG_THRESH_RST = 12'h100;
    localparam logic        CFG_EN_RST     = 1'b1;

    localparam int RESULT_W = $bits(ipu_result_t);

endpackage

// ==== ipu_core.sv ====
// camera-domain pixel classifier with raster counting and per-frame bounding-box tracking.
`timescale 1ns/1ns

module ipu_core
    import ipu_pkg::*;
#(
    parameter int IMG_W = 640,
    parameter int IMG_H = 480
) (
    input  logic        i_cam_clk,
    input  logic        i_cam_rst_n,
    input  logic        i_dval,
    input  pixel_t      i_pixel,
    input  ipu_cfg_t    i_cfg,
    output logic        o_res_vld,
    output ipu_result_t o_res
);

    localparam logic [9:0] COL_LAST = 10'(IMG_W - 1);
    localparam logic [9:0] ROW_LAST = 10'(IMG_H - 1);

    logic [9:0]  col;
    logic [9:0]  row;
    logic [12:0] g_lim;
    logic [12:0] b_lim;
    logic        is_target;
    logic        hit;
    logic        frame_end;
    logic        seen;
    logic        seen_nxt;
    logic [9:0]  min_row;
    logic [9:0]  max_row;
    logic [9:0]  min_col;
    logic [9:0]  max_col;
    logic [9:0]  min_row_nxt;
    logic [9:0]  max_row_nxt;
    logic [9:0]  min_col_nxt;
    logic [9:0]  max_col_nxt;
    logic [10:0] row_sum;
    logic [10:0] col_sum;

    // the sums carry one extra bit so a large threshold cannot wrap.
    assign g_lim = {1'b0, i_pixel.green} + {1'b0, i_cfg.thresh};
    assign b_lim = {1'b0, i_pixel.blue} + {1'b0, i_cfg.thresh};
    assign is_target = ({1'b0, i_pixel.red} > g_lim) && ({1'b0, i_pixel.red} > b_lim);

    assign hit       = i_dval && is_target;
    assign frame_end = i_dval && (col == COL_LAST) && (row == ROW_LAST);

    always_ff @(posedge i_cam_clk or negedge i_cam_rst_n) begin
        if (!i_cam_rst_n) begin
            col <= '0;
            row <= '0;
        end else if (i_dval) begin
            if (col == COL_LAST) begin
                col <= '0;
                row <= (row == ROW_LAST) ? '0 : row + 10'd1;
            end else begin
                col <= col + 10'd1;
            end
        end
    end

    // the box including the current pixel, so the last pixel of a frame still counts.
    always_comb begin
        seen_nxt    = seen;
        min_row_nxt = min_row;
        max_row_nxt = max_row;
        min_col_nxt = min_col;
        max_col_nxt = max_col;
        if (hit) begin
            seen_nxt = 1'b1;
            if (!seen || row < min_row) min_row_nxt = row;
            if (!seen || row > max_row) max_row_nxt = row;
            if (!seen || col < min_col) min_col_nxt = col;
            if (!seen || col > max_col) max_col_nxt = col;
        end
    end

    assign row_sum = {1'b0, min_row_nxt} + {1'b0, max_row_nxt};
    assign col_sum = {1'b0, min_col_nxt} + {1'b0, max_col_nxt};

    always_ff @(posedge i_cam_clk or negedge i_cam_rst_n) begin
        if (!i_cam_rst_n) begin
            seen      <= 1'b0;
            o_res_vld <= 1'b0;
        end else begin
            seen      <= frame_end ? 1'b0 : seen_nxt;
            o_res_vld <= frame_end && i_cfg.en;
        end
    end

    // box bounds are only meaningful while seen is set.
    always_ff @(posedge i_cam_clk) begin
        min_row <= min_row_nxt;
        max_row <= max_row_nxt;
        min_col <= min_col_nxt;
        max_col <= max_col_nxt;
    end

    always_ff @(posedge i_cam_clk) begin
        if (frame_end) begin
            o_res.present <= seen_nxt;
            o_res.row     <= seen_nxt ? row_sum[10:1] : '0;
            o_res.col     <= seen_nxt ? col_sum[10:1] : '0;
        end
    end

endmodule

// ==== async_fifo.sv ====
// dual-clock FIFO with Gray-coded pointers and first-word-fall-through read data.
`timescale 1ns/1ns

module async_fifo
    import ipu_pkg::*;
#(
    parameter int FIFO_DEPTH = 4,
    parameter int DATA_W     = RESULT_W
) (
    input  logic              i_wclk,
    input  logic              i_wrst_n,
    input  logic              i_wr,
    input  logic [DATA_W-1:0] i_wdata,
    output logic              o_full,
    input  logic              i_rclk,
    input  logic              i_rrst_n,
    input  logic              i_rd,
    output logic [DATA_W-1:0] o_rdata,
    output logic              o_empty
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [DATA_W-1:0] mem [FIFO_DEPTH];

    logic [AW:0] wbin;
    logic [AW:0] wgray;
    logic [AW:0] wbin_nxt;
    logic [AW:0] wgray_nxt;
    logic [AW:0] rbin;
    logic [AW:0] rgray;
    logic [AW:0] rbin_nxt;
    logic [AW:0] rgray_nxt;
    logic [AW:0] wq1_rgray;
    logic [AW:0] wq2_rgray;
    logic [AW:0] rq1_wgray;
    logic [AW:0] rq2_wgray;

    assign wbin_nxt  = wbin + ((i_wr && !o_full) ? 1'b1 : 1'b0);
    assign wgray_nxt = (wbin_nxt >> 1) ^ wbin_nxt;
    assign rbin_nxt  = rbin + ((i_rd && !o_empty) ? 1'b1 : 1'b0);
    assign rgray_nxt = (rbin_nxt >> 1) ^ rbin_nxt;

    always_ff @(posedge i_wclk) begin
        if (i_wr && !o_full) mem[wbin[AW-1:0]] <= i_wdata;
    end

    // full when the write pointer has lapped the read pointer once.
    always_ff @(posedge i_wclk or negedge i_wrst_n) begin
        if (!i_wrst_n) begin
            wbin      <= '0;
            wgray     <= '0;
            wq1_rgray <= '0;
            wq2_rgray <= '0;
            o_full    <= 1'b0;
        end else begin
            wbin      <= wbin_nxt;
            wgray     <= wgray_nxt;
            wq1_rgray <= rgray;
            wq2_rgray <= wq1_rgray;
            o_full    <= wgray_nxt == (wq2_rgray ^ {2'b11, {(AW - 1){1'b0}}});
        end
    end

    always_ff @(posedge i_rclk or negedge i_rrst_n) begin
        if (!i_rrst_n) begin
            rbin      <= '0;
            rgray     <= '0;
            rq1_wgray <= '0;
            rq2_wgray <= '0;
            o_empty   <= 1'b1;
        end else begin
            rbin      <= rbin_nxt;
            rgray     <= rgray_nxt;
            rq1_wgray <= wgray;
            rq2_wgray <= rq1_wgray;
            o_empty   <= rgray_nxt == rq2_wgray;
        end
    end

    assign o_rdata = mem[rbin[AW-1:0]];

endmodule

// ==== ipu_result_reg.sv ====
// read-only result register that drains the FIFO and clears its valid bit on a bus read.
`timescale 1ns/1ns

module ipu_result_reg
    import ipu_pkg::*;
#(
    parameter logic [31:0] BASE_ADDR = 32'h40000200
) (
    input  logic        sys_clk,
    input  logic        rst_n,
    input  ipu_result_t i_fifo_data,
    input  logic        i_fifo_empty,
    output logic        o_fifo_rd,
    input  bus_req_t    i_bus,
    output bus_resp_t   o_resp
);

    localparam logic [31:0] RES_ADDR = BASE_ADDR + RESULT_OFS;

    ipu_result_t result;
    logic        valid;
    logic        hit;
    logic        rd_hit;

    assign hit    = i_bus.addr[31:2] == RES_ADDR[31:2];
    assign rd_hit = hit && i_bus.rd;

    // at most one result per frame, so popping every non-empty cycle is enough.
    assign o_fifo_rd = !i_fifo_empty;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (o_fifo_rd) begin
            result <= i_fifo_data;
        end
    end

    // a new result takes priority over the read that would clear valid.
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (o_fifo_rd) begin
            valid <= 1'b1;
        end else if (rd_hit) begin
            valid <= 1'b0;
        end
    end

    assign o_resp.ack   = hit && (i_bus.rd || i_bus.wr);
    assign o_resp.rdata = o_resp.ack ?
        {10'd0, result.col, result.row, result.present, valid} : 32'd0;

endmodule

// ==== ipu_cfg_regs.sv ====
// configuration register holding the detection threshold and the result enable.
`timescale 1ns/1ns

module ipu_cfg_regs
    import ipu_pkg::*;
#(
    parameter logic [31:0] BASE_ADDR = 32'h40000200
) (
    input  logic      sys_clk,
    input  logic      rst_n,
    input  bus_req_t  i_bus,
    output bus_resp_t o_resp,
    output ipu_cfg_t  o_cfg
);

    localparam logic [31:0] CFG_ADDR = BASE_ADDR + CFG_OFS;

    logic hit;

    assign hit = i_bus.addr[31:2] == CFG_ADDR[31:2];

    // the core samples these as static levels, software changes them between frames.
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            o_cfg.thresh <= CFG_THRESH_RST;
            o_cfg.en     <= CFG_EN_RST;
        end else if (hit && i_bus.wr) begin
            o_cfg.thresh <= i_bus.wdata[11:0];
            o_cfg.en     <= i_bus.wdata[16];
        end
    end

    assign o_resp.ack   = hit && (i_bus.rd || i_bus.wr);
    assign o_resp.rdata = o_resp.ack ? {15'd0, o_cfg.en, 4'd0, o_cfg.thresh} : 32'd0;

endmodule

// ==== bus_resp_mux.sv ====
// merges the slave responses into the one bus read data and acknowledge.
`timescale 1ns/1ns

module bus_resp_mux
    import ipu_pkg::*;
(
    input  bus_resp_t i_resp_res,
    input  bus_resp_t i_resp_cfg,
    output bus_resp_t o_resp
);

    // the slaves decode disjoint addresses, so at most one acknowledges.
    always_comb begin
        o_resp.ack = i_resp_res.ack || i_resp_cfg.ack;
        if (i_resp_res.ack) begin
            o_resp.rdata = i_resp_res.rdata;
        end else if (i_resp_cfg.ack) begin
            o_resp.rdata = i_resp_cfg.rdata;
        end else begin
            o_resp.rdata = 32'd0;
        end
    end

endmodule

// ==== ipu_top.sv ====
// image processing unit top with camera core, clock crossing FIFO and bus registers.
`timescale 1ns/1ns

module ipu_top
    import ipu_pkg::*;
#(
    parameter logic [31:0] BASE_ADDR  = 32'h40000200,
    parameter int          IMG_W      = 640,
    parameter int          IMG_H      = 480,
    parameter int          FIFO_DEPTH = 4
) (
    input  logic      sys_clk,
    input  logic      rst_n,
    input  logic      i_cam_clk,
    input  logic      i_cam_rst_n,
    input  logic      i_dval,
    input  pixel_t    i_pixel,
    input  bus_req_t  i_bus,
    output bus_resp_t o_bus
);

    ipu_cfg_t    cfg;
    logic        res_vld;
    ipu_result_t res;
    ipu_result_t fifo_data;
    logic        fifo_empty;
    logic        fifo_rd;
    bus_resp_t   resp_res;
    bus_resp_t   resp_cfg;

    ipu_core #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) ipu_core_i (
        .i_cam_clk   (i_cam_clk),
        .i_cam_rst_n (i_cam_rst_n),
        .i_dval      (i_dval),
        .i_pixel     (i_pixel),
        .i_cfg       (cfg),
        .o_res_vld   (res_vld),
        .o_res       (res)
    );

    async_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .DATA_W     (RESULT_W)
    ) async_fifo_i (
        .i_wclk   (i_cam_clk),
        .i_wrst_n (i_cam_rst_n),
        .i_wr     (res_vld),
        .i_wdata  (res),
        .o_full   (),
        .i_rclk   (sys_clk),
        .i_rrst_n (rst_n),
        .i_rd     (fifo_rd),
        .o_rdata  (fifo_data),
        .o_empty  (fifo_empty)
    );

    ipu_result_reg #(
        .BASE_ADDR (BASE_ADDR)
    ) ipu_result_reg_i (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .i_fifo_data  (fifo_data),
        .i_fifo_empty (fifo_empty),
        .o_fifo_rd    (fifo_rd),
        .i_bus        (i_bus),
        .o_resp       (resp_res)
    );

    ipu_cfg_regs #(
        .BASE_ADDR (BASE_ADDR)
    ) ipu_cfg_regs_i (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .i_bus   (i_bus),
        .o_resp  (resp_cfg),
        .o_cfg   (cfg)
    );

    bus_resp_mux bus_resp_mux_i (
        .i_resp_res (resp_res),
        .i_resp_cfg (resp_cfg),
        .o_resp     (o_bus)
    );

endmodule

// ==== tb_ipu_tasks.svh ====
// bus access, camera frame and compare tasks for the image processing unit testbench.
`ifndef TB_IPU_TASKS_SVH
`define TB_IPU_TASKS_SVH

// one bus cycle per access, with the response sampled mid-cycle where it is stable.
task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge sys_clk);
    bus_req <= '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
    @(negedge sys_clk);
    check_bit("write ack", bus_resp.ack, 1'b1);
    @(posedge sys_clk);
    bus_req <= '0;
endtask

task automatic bus_read(input logic [31:0] addr, output logic [31:0] data, output logic ack);
    @(posedge sys_clk);
    bus_req <= '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: 32'd0};
    @(negedge sys_clk);
    data = bus_resp.rdata;
    ack  = bus_resp.ack;
    @(posedge sys_clk);
    bus_req <= '0;
endtask

// result word: col in 21:12, row in 11:2, present in 1, valid in 0.
function automatic ipu_result_t decode_result(input logic [31:0] d);
    ipu_result_t r;
    r.present = d[1];
    r.row     = d[11:2];
    r.col     = d[21:12];
    return r;
endfunction

function automatic ipu_cfg_t decode_cfg(input logic [31:0] d);
    ipu_cfg_t c;
    c.thresh = d[11:0];
    c.en     = d[16];
    return c;
endfunction

// the expected center is the halved sum of the box bounds.
function automatic ipu_result_t box_center(input int r0, input int r1, input int c0, input int c1);
    ipu_result_t r;
    r.present = 1'b1;
    r.row     = 10'((r0 + r1) / 2);
    r.col     = 10'((c0 + c1) / 2);
    return r;
endfunction

task automatic drive_frame(input int r0, input int r1, input int c0, input int c1,
                           input pixel_t tgt, input pixel_t bg);
    int r;
    int c;
    for (r = 0; r < IMG_H; r++) begin
        for (c = 0; c < IMG_W; c++) begin
            @(posedge cam_clk);
            dval  <= 1'b1;
            pixel <= (r >= r0 && r <= r1 && c >= c0 && c <= c1) ? tgt : bg;
        end
    end
    @(posedge cam_clk);
    dval  <= 1'b0;
    pixel <= '0;
endtask

// polls the result register until valid reads back as 1.
task automatic wait_result(output ipu_result_t res);
    logic [31:0] d;
    logic        ack;
    int          polls;
    d     = 32'd0;
    polls = 0;
    while (d[0] !== 1'b1 && polls < POLL_LIMIT) begin
        bus_read(RES_ADDR, d, ack);
        polls++;
    end
    if (d[0] !== 1'b1) begin
        $display("no valid result arrived within %0d polls", POLL_LIMIT);
        err_cnt++;
    end
    res = decode_result(d);
endtask

task automatic check_result(input string name, input ipu_result_t got, input ipu_result_t exp);
    if (got !== exp) begin
        $display("ERR %s present/row/col got %h/%h/%h expected %h/%h/%h", name,
                 got.present, got.row, got.col, exp.present, exp.row, exp.col);
        err_cnt++;
    end
endtask

task automatic check_cfg(input string name, input ipu_cfg_t got, input ipu_cfg_t exp);
    if (got !== exp) begin
        $display("ERR %s thresh/en got %h/%h expected %h/%h", name,
                 got.thresh, got.en, exp.thresh, exp.en);
        err_cnt++;
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("ERR %s got %h expected %h", name, got, exp);
        err_cnt++;
    end
endtask

`endif

// ==== tb_ipu_top.sv ====
// testbench for the image processing unit, driving camera frames and checking bus results.
`timescale 1ns/1ns

module tb_ipu_top
    import ipu_pkg::*;
();

    localparam logic [31:0] BASE_ADDR  = 32'h40000200;
    localparam int          IMG_W      = 16;
    localparam int          IMG_H      = 12;
    localparam int          SYS_PERIOD = 8;
    localparam int          CAM_PERIOD = 14;
    localparam int          FRAMES     = 13;
    localparam int          POLL_LIMIT = 50;
    // every frame may also use a full poll budget and a few register accesses.
    localparam int TIMEOUT_CYC = FRAMES * IMG_W * IMG_H * CAM_PERIOD / SYS_PERIOD
                                 + FRAMES * (2 * POLL_LIMIT + 40) + 200;

    localparam logic [31:0] RES_ADDR   = BASE_ADDR;
    localparam logic [31:0] CFG_ADDR   = BASE_ADDR + 32'd4;
    localparam logic [31:0] UNMAP_ADDR = BASE_ADDR + 32'd8;

    logic        sys_clk;
    logic        rst_n;
    logic        cam_clk;
    logic        cam_rst_n;
    logic        dval;
    pixel_t      pixel;
    bus_req_t    bus_req;
    bus_resp_t   bus_resp;
    int          err_cnt;
    int          cyc_cnt;
    logic [11:0] cur_thr;

    `include "tb_ipu_tasks.svh"

    ipu_top #(
        .BASE_ADDR  (BASE_ADDR),
        .IMG_W      (IMG_W),
        .IMG_H      (IMG_H),
        .FIFO_DEPTH (4)
    ) ipu_top_i (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .i_cam_clk   (cam_clk),
        .i_cam_rst_n (cam_rst_n),
        .i_dval      (dval),
        .i_pixel     (pixel),
        .i_bus       (bus_req),
        .o_bus       (bus_resp)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(SYS_PERIOD / 2) sys_clk = ~sys_clk;
    end

    initial begin
        cam_clk = 1'b0;
        forever #(CAM_PERIOD / 2) cam_clk = ~cam_clk;
    end

    initial begin
        cam_rst_n = 1'b0;
        repeat (10) @(posedge cam_clk);
        cam_rst_n <= 1'b1;
    end

    always @(posedge sys_clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= TIMEOUT_CYC) begin
            $display("timeout after %0d sys_clk cycles, errors: %0d", cyc_cnt, err_cnt);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic run_reset_checks();
        logic [31:0] d;
        logic        ack;
        ipu_cfg_t    exp;
        exp.thresh = 12'h100;
        exp.en     = 1'b1;
        bus_read(RES_ADDR, d, ack);
        check_bit("result ack", ack, 1'b1);
        check_bit("result valid", d[0], 1'b0);
        check_bit("result present", d[1], 1'b0);
        bus_read(CFG_ADDR, d, ack);
        check_bit("cfg ack", ack, 1'b1);
        check_cfg("cfg after reset", decode_cfg(d), exp);
        bus_read(UNMAP_ADDR, d, ack);
        check_bit("unmapped ack", ack, 1'b0);
        check_bit("unmapped rdata nonzero", |d, 1'b0);
    endtask

    task automatic single_rect();
        pixel_t      tgt;
        pixel_t      bg;
        ipu_result_t res;
        tgt = '{red: 12'h800, green: 12'h100, blue: 12'h100};
        bg  = '{red: 12'h100, green: 12'h100, blue: 12'h100};
        drive_frame(3, 7, 4, 11, tgt, bg);
        wait_result(res);
        check_result("single rect", res, box_center(3, 7, 4, 11));
    endtask

    task automatic empty_frame();
        pixel_t      bg;
        ipu_result_t res;
        bg = '{red: 12'h200, green: 12'h300, blue: 12'h100};
        drive_frame(0, 0, 0, 0, bg, bg);
        wait_result(res);
        check_result("empty frame", res, '0);
    endtask

    task automatic threshold_margin();
        logic [31:0] d;
        logic        ack;
        ipu_cfg_t    exp;
        pixel_t      tgt;
        pixel_t      bg;
        ipu_result_t res;
        cur_thr    = 12'h080;
        exp.thresh = cur_thr;
        exp.en     = 1'b1;
        bus_write(CFG_ADDR, {15'd0, 1'b1, 4'd0, cur_thr});
        bus_read(CFG_ADDR, d, ack);
        check_cfg("cfg threshold", decode_cfg(d), exp);
        bg  = '{red: 12'h000, green: 12'h200, blue: 12'h200};
        tgt = bg;
        // a margin equal to the threshold is not enough.
        tgt.red = 12'h200 + cur_thr;
        drive_frame(2, 5, 2, 5, tgt, bg);
        wait_result(res);
        check_result("margin at threshold", res, '0);
        tgt.red = 12'h201 + cur_thr;
        drive_frame(2, 5, 2, 5, tgt, bg);
        wait_result(res);
        check_result("margin above threshold", res, box_center(2, 5, 2, 5));
    endtask

    task automatic valid_and_enable();
        logic [31:0] d;
        logic        ack;
        ipu_cfg_t    exp;
        pixel_t      tgt;
        pixel_t      bg;
        tgt = '{red: 12'hf00, green: 12'h010, blue: 12'h010};
        bg  = '{red: 12'h010, green: 12'h010, blue: 12'h010};
        bus_read(RES_ADDR, d, ack);
        check_bit("valid on second read", d[0], 1'b0);
        bus_write(CFG_ADDR, {15'd0, 1'b0, 4'd0, cur_thr});
        drive_frame(1, 4, 1, 4, tgt, bg);
        // longer than one camera cycle plus the three sys_clk cycles of the crossing.
        repeat (20) @(posedge sys_clk);
        bus_read(RES_ADDR, d, ack);
        check_bit("valid with enable off", d[0], 1'b0);
        exp.thresh = cur_thr;
        exp.en     = 1'b1;
        bus_write(CFG_ADDR, {15'd0, 1'b1, 4'd0, cur_thr});
        bus_read(CFG_ADDR, d, ack);
        check_cfg("cfg enable restored", decode_cfg(d), exp);
    endtask

    task automatic random_rects();
        int          i;
        int          r0;
        int          r1;
        int          c0;
        int          c1;
        int          g;
        int          b;
        int          mx;
        pixel_t      tgt;
        pixel_t      bg;
        ipu_result_t res;
        for (i = 0; i < 8; i++) begin
            r0 = int'($urandom % IMG_H);
            r1 = r0 + int'($urandom % (IMG_H - r0));
            c0 = int'($urandom % IMG_W);
            c1 = c0 + int'($urandom % (IMG_W - c0));
            g  = int'($urandom % 1024);
            b  = int'($urandom % 1024);
            mx = (g > b) ? g : b;
            tgt.green = 12'(g);
            tgt.blue  = 12'(b);
            tgt.red   = 12'(mx + int'(cur_thr) + 1 + int'($urandom % 256));
            bg        = tgt;
            bg.red    = 12'(int'($urandom % (mx + int'(cur_thr) + 1)));
            drive_frame(r0, r1, c0, c1, tgt, bg);
            wait_result(res);
            check_result($sformatf("random rect %0d", i), res, box_center(r0, r1, c0, c1));
        end
    endtask

    initial begin
        err_cnt = 0;
        cyc_cnt = 0;
        cur_thr = 12'h100;
        rst_n   = 1'b0;
        dval    = 1'b0;
        pixel   = '0;
        bus_req = '0;
        void'($urandom(32'ha320));
        repeat (10) @(posedge sys_clk);
        rst_n <= 1'b1;
        wait (cam_rst_n === 1'b1);
        @(posedge sys_clk);
        run_reset_checks();
        single_rect();
        empty_frame();
        threshold_margin();
        valid_and_enable();
        random_rects();
        $display("errors: %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+.
ipu_pkg.sv
ipu_core.sv
async_fifo.sv
ipu_result_reg.sv
ipu_cfg_regs.sv
bus_resp_mux.sv
ipu_top.sv
tb_ipu_top.sv

// ==== Makefile ====
# Verilator build for the image processing unit testbench.

VERILATOR ?= verilator
TOP       ?= tb_ipu_top
RTL_TOP   ?= ipu_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
